/* verilog/axi_rd_pkg.sv */
package axi_rd_pkg;

    // bus geometry
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W   = 4;
    localparam int LEN_W  = 8;    // burst length in beats, 1 to 255

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [LEN_W-1:0]  burst_len_t;

    // the encoding doubles as arid / rid
    typedef enum logic [ID_W-1:0] {
        MST_DCACHE = ID_W'(0),
        MST_ICACHE = ID_W'(1)
    } master_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,    // waiting for a request
        ST_ADDR = 2'b01,    // arvalid up
        ST_DATA = 2'b10     // collecting beats
    } bridge_state_e;

endpackage

/* verilog/rd_req_if.sv */
`timescale 1ns/1ns

// one master's read request, held until ready pulses
interface rd_req_if;

    logic                   valid;
    axi_rd_pkg::addr_t      addr;    // byte address, word aligned
    axi_rd_pkg::burst_len_t len;     // beats, never zero
    logic                   ready;   // single cycle grant pulse

    // arbiter side sees the request level and answers it
    modport grant_mp (
        input  valid,
        output ready
    );

    // address mux side only needs the payload
    modport fetch_mp (
        input  addr,
        input  len
    );

endinterface

/* verilog/rd_arbiter_ctrl.sv */
`timescale 1ns/1ns

module rd_arbiter_ctrl (
    input  logic                aclk,
    input  logic                rst_n_i,
    input  logic                arready_i,
    input  logic                burst_done_i,
    rd_req_if.grant_mp          dcache_req,
    rd_req_if.grant_mp          icache_req,
    output axi_rd_pkg::master_e grant_o,
    output logic                latch_o,
    output logic                ar_phase_o
);
    import axi_rd_pkg::*;

    bridge_state_e state_q;
    bridge_state_e state_d;
    master_e       last_q;      // winner of the previous grant
    master_e       pick;
    logic          any_req;

    assign any_req = dcache_req.valid | icache_req.valid;

    // round robin pick, only the loser of last time wins a tie
    always_comb begin
        pick = MST_DCACHE;
        if (dcache_req.valid && icache_req.valid) begin
            pick = (last_q == MST_DCACHE) ? MST_ICACHE : MST_DCACHE;
        end else if (icache_req.valid) begin
            pick = MST_ICACHE;
        end
    end

    assign latch_o    = (state_q == ST_IDLE) && any_req;
    assign grant_o    = pick;
    assign ar_phase_o = (state_q == ST_ADDR);

    assign dcache_req.ready = latch_o && (pick == MST_DCACHE);
    assign icache_req.ready = latch_o && (pick == MST_ICACHE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (any_req) begin
                    state_d = ST_ADDR;
                end
            end
            ST_ADDR: begin
                if (arready_i) begin
                    state_d = ST_DATA;
                end
            end
            ST_DATA: begin
                if (burst_done_i) begin
                    state_d = ST_IDLE;    // no grant in this cycle
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            last_q  <= MST_ICACHE;    // data side first after reset
        end else begin
            state_q <= state_d;
            if (latch_o) begin
                last_q <= pick;
            end
        end
    end

    // a master keeps its request up until the grant pulse takes it
    a_dcache_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
        dcache_req.valid && !dcache_req.ready |=> dcache_req.valid);

    a_icache_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
        icache_req.valid && !icache_req.ready |=> icache_req.valid);

    // the router may only report a finished burst while data is expected
    a_done_in_data: assert property (@(posedge aclk) disable iff (!rst_n_i)
        burst_done_i |-> state_q == ST_DATA);

endmodule

/* verilog/ar_channel_mux.sv */
`timescale 1ns/1ns

module ar_channel_mux (
    input  logic                   aclk,
    input  logic                   rst_n_i,
    input  axi_rd_pkg::master_e    grant_i,
    input  logic                   latch_i,
    input  logic                   ar_phase_i,
    rd_req_if.fetch_mp             dcache_req,
    rd_req_if.fetch_mp             icache_req,
    output logic                   arvalid_o,
    output axi_rd_pkg::master_e    arid_o,
    output axi_rd_pkg::addr_t      araddr_o,
    output axi_rd_pkg::burst_len_t arlen_o
);
    import axi_rd_pkg::*;

    addr_t      sel_addr;
    burst_len_t sel_len;

    // payload of whichever master the arbiter picked
    always_comb begin
        if (grant_i == MST_ICACHE) begin
            sel_addr = icache_req.addr;
            sel_len  = icache_req.len;
        end else begin
            sel_addr = dcache_req.addr;
            sel_len  = dcache_req.len;
        end
    end

    // fields stay put through the whole address phase
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arid_o   <= MST_DCACHE;
            araddr_o <= '0;
            arlen_o  <= '0;
        end else if (latch_i) begin
            arid_o   <= grant_i;
            araddr_o <= sel_addr;
            arlen_o  <= sel_len - burst_len_t'(1);    // axi counts beats minus one
        end
    end

    assign arvalid_o = ar_phase_i;

    // a zero length request would wrap arlen to 255
    a_len_nonzero: assert property (@(posedge aclk) disable iff (!rst_n_i)
        latch_i |-> sel_len != '0);

endmodule

/* verilog/r_channel_router.sv */
`timescale 1ns/1ns

module r_channel_router (
    input  logic                   aclk,
    input  logic                   rst_n_i,
    input  axi_rd_pkg::master_e    rid_i,
    input  axi_rd_pkg::data_t      rdata_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i,
    input  axi_rd_pkg::burst_len_t arlen_i,
    output logic                   dcache_valid_o,
    output logic                   dcache_last_o,
    output axi_rd_pkg::data_t      dcache_data_o,
    output logic                   icache_valid_o,
    output logic                   icache_last_o,
    output axi_rd_pkg::data_t      icache_data_o,
    output logic                   burst_done_o
);
    import axi_rd_pkg::*;

    logic       to_dcache;
    logic       to_icache;
    burst_len_t beat_cnt;    // beats already seen in this burst

    // rid names the master directly
    assign to_dcache = rvalid_i && (rid_i == MST_DCACHE);
    assign to_icache = rvalid_i && (rid_i == MST_ICACHE);

    assign dcache_valid_o = to_dcache;
    assign dcache_last_o  = to_dcache && rlast_i;
    assign dcache_data_o  = rdata_i;

    assign icache_valid_o = to_icache;
    assign icache_last_o  = to_icache && rlast_i;
    assign icache_data_o  = rdata_i;

    assign burst_done_o = rvalid_i && rlast_i;

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beat_cnt <= '0;
        end else if (rvalid_i) begin
            if (rlast_i) begin
                beat_cnt <= '0;    // ready for the next burst
            end else begin
                beat_cnt <= beat_cnt + burst_len_t'(1);
            end
        end
    end

    // slave must end the burst exactly after arlen + 1 beats
    a_last_on_count: assert property (@(posedge aclk) disable iff (!rst_n_i)
        rvalid_i |-> (rlast_i == (beat_cnt == arlen_i)));

endmodule

/* verilog/axi_rd_bridge_top.sv */
`timescale 1ns/1ns

module axi_rd_bridge_top (
    input  logic                   aclk,
    input  logic                   rst_n_i,
    // data side master
    input  logic                   dcache_rd_valid_i,
    input  axi_rd_pkg::addr_t      dcache_rd_addr_i,
    input  axi_rd_pkg::burst_len_t dcache_rd_len_i,
    output logic                   dcache_rd_ready_o,
    output logic                   dcache_data_valid_o,
    output logic                   dcache_data_last_o,
    output axi_rd_pkg::data_t      dcache_data_o,
    // instruction side master
    input  logic                   icache_rd_valid_i,
    input  axi_rd_pkg::addr_t      icache_rd_addr_i,
    input  axi_rd_pkg::burst_len_t icache_rd_len_i,
    output logic                   icache_rd_ready_o,
    output logic                   icache_data_valid_o,
    output logic                   icache_data_last_o,
    output axi_rd_pkg::data_t      icache_data_o,
    // axi read address channel
    output logic                   arvalid_o,
    input  logic                   arready_i,
    output axi_rd_pkg::master_e    arid_o,
    output axi_rd_pkg::addr_t      araddr_o,
    output axi_rd_pkg::burst_len_t arlen_o,
    // axi read data channel, always accepted
    input  axi_rd_pkg::master_e    rid_i,
    input  axi_rd_pkg::data_t      rdata_i,
    input  logic                   rlast_i,
    input  logic                   rvalid_i
);
    import axi_rd_pkg::*;

    master_e grant;
    logic    latch;
    logic    ar_phase;
    logic    burst_done;

    rd_req_if dcache_req ();
    rd_req_if icache_req ();

    assign dcache_req.valid  = dcache_rd_valid_i;
    assign dcache_req.addr   = dcache_rd_addr_i;
    assign dcache_req.len    = dcache_rd_len_i;
    assign dcache_rd_ready_o = dcache_req.ready;

    assign icache_req.valid  = icache_rd_valid_i;
    assign icache_req.addr   = icache_rd_addr_i;
    assign icache_req.len    = icache_rd_len_i;
    assign icache_rd_ready_o = icache_req.ready;

    rd_arbiter_ctrl u_ctrl (
        .aclk         (aclk),
        .rst_n_i      (rst_n_i),
        .arready_i    (arready_i),
        .burst_done_i (burst_done),
        .dcache_req   (dcache_req.grant_mp),
        .icache_req   (icache_req.grant_mp),
        .grant_o      (grant),
        .latch_o      (latch),
        .ar_phase_o   (ar_phase)
    );

    ar_channel_mux u_ar (
        .aclk       (aclk),
        .rst_n_i    (rst_n_i),
        .grant_i    (grant),
        .latch_i    (latch),
        .ar_phase_i (ar_phase),
        .dcache_req (dcache_req.fetch_mp),
        .icache_req (icache_req.fetch_mp),
        .arvalid_o  (arvalid_o),
        .arid_o     (arid_o),
        .araddr_o   (araddr_o),
        .arlen_o    (arlen_o)
    );

    r_channel_router u_r (
        .aclk           (aclk),
        .rst_n_i        (rst_n_i),
        .rid_i          (rid_i),
        .rdata_i        (rdata_i),
        .rlast_i        (rlast_i),
        .rvalid_i       (rvalid_i),
        .arlen_i        (arlen_o),    // beat count reference
        .dcache_valid_o (dcache_data_valid_o),
        .dcache_last_o  (dcache_data_last_o),
        .dcache_data_o  (dcache_data_o),
        .icache_valid_o (icache_data_valid_o),
        .icache_last_o  (icache_data_last_o),
        .icache_data_o  (icache_data_o),
        .burst_done_o   (burst_done)
    );

endmodule

/* testbench/tb_axi_rd_bridge.sv */
`timescale 1ns/1ns

module tb_axi_rd_bridge;
    import axi_rd_pkg::*;

    localparam int CLK_PERIOD      = 100;
    localparam int TOTAL_BEATS     = 5 + 5 + 15 + 8 + 20 * 16;    // upper bound over all tests
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 20 + 200;

    logic       aclk;
    logic       rst_n_i;
    logic       dcache_rd_valid_i, icache_rd_valid_i;
    addr_t      dcache_rd_addr_i, icache_rd_addr_i;
    burst_len_t dcache_rd_len_i, icache_rd_len_i;
    logic       dcache_rd_ready_o, icache_rd_ready_o;
    logic       dcache_data_valid_o, dcache_data_last_o;
    logic       icache_data_valid_o, icache_data_last_o;
    data_t      dcache_data_o, icache_data_o;
    logic       arvalid_o, arready_i;
    master_e    arid_o, rid_i;
    addr_t      araddr_o;
    burst_len_t arlen_o;
    data_t      rdata_i;
    logic       rlast_i, rvalid_i;

    logic [31:0] lfsr_q;
    master_e     last_winner;    // expected round robin pointer

    axi_rd_bridge_top dut0 (.*);

    initial aclk = 1'b0;
    always #(CLK_PERIOD / 2) aclk = ~aclk;

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_len(input string name, input burst_len_t exp, input burst_len_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_id(input string name, input master_e exp, input master_e act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected 0x%h, got 0x%h", name, exp, act);
            abort_run();
        end
    endtask

    // right shifting galois lfsr
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = galois_step(lfsr_q);
            v[i]   = lfsr_q[0];    // one step per bit
        end
    endtask

    // slave memory contents, word k of a burst
    function automatic data_t beat_pattern(input addr_t base, input int k);
        return data_t'(base + addr_t'(4 * k)) ^ 32'h5a5a_0000;
    endfunction

    function automatic logic ready_of(input master_e m);
        return (m == MST_ICACHE) ? icache_rd_ready_o : dcache_rd_ready_o;
    endfunction

    task automatic next_cycle();
        @(posedge aclk);
        #5;
    endtask

    task automatic set_req(input master_e mst, input addr_t addr, input burst_len_t len);
        if (mst == MST_ICACHE) begin
            icache_rd_valid_i = 1'b1;
            icache_rd_addr_i  = addr;
            icache_rd_len_i   = len;
        end else begin
            dcache_rd_valid_i = 1'b1;
            dcache_rd_addr_i  = addr;
            dcache_rd_len_i   = len;
        end
    endtask

    task automatic check_ar(input master_e mst, input addr_t addr, input burst_len_t len);
        check_bit("arvalid_o", 1'b1, arvalid_o);
        check_id("arid_o", mst, arid_o);
        check_addr("araddr_o", addr, araddr_o);
        check_len("arlen_o", len - burst_len_t'(1), arlen_o);
    endtask

    // one burst from the grant to the beat after rlast, slave side included
    task automatic read_burst(input master_e mst, input addr_t addr, input burst_len_t len,
                              input int ar_stall, input int gap_max);
        master_e     other;
        int          waited;
        int          stall;
        int          gap;
        logic [31:0] r;
        logic        is_last;
        data_t       exp_word;
        other  = (mst == MST_DCACHE) ? MST_ICACHE : MST_DCACHE;
        waited = 0;
        stall  = ar_stall;
        #1;
        while (!ready_of(mst)) begin
            if (waited == 40) begin
                $display("master %0d was never granted the bus", mst);
                abort_run();
            end else begin
                waited++;
                next_cycle();
                #1;
            end
        end
        check_bit(other == MST_ICACHE ? "icache_rd_ready_o" : "dcache_rd_ready_o", 1'b0,
                  ready_of(other));
        check_bit("arvalid_o", 1'b0, arvalid_o);    // still idle in the grant cycle
        last_winner = mst;
        next_cycle();
        if (mst == MST_ICACHE) begin
            icache_rd_valid_i = 1'b0;
        end else begin
            dcache_rd_valid_i = 1'b0;
        end
        arready_i = (stall == 0);
        #1;
        check_bit(mst == MST_ICACHE ? "icache_rd_ready_o" : "dcache_rd_ready_o", 1'b0,
                  ready_of(mst));
        check_ar(mst, addr, len);
        while (stall > 0) begin
            next_cycle();
            stall--;
            arready_i = (stall == 0);
            #1;
            check_ar(mst, addr, len);    // held while stalled
        end
        next_cycle();
        arready_i = 1'b0;
        for (int k = 0; k < int'(len); k++) begin
            gap = 0;
            if (gap_max > 0) begin
                rand_bits(2, r);
                gap = int'(r[1:0]) % (gap_max + 1);
            end
            repeat (gap) begin
                rvalid_i = 1'b0;
                rlast_i  = 1'b0;
                #1;
                check_bit("dcache_data_valid_o", 1'b0, dcache_data_valid_o);
                check_bit("icache_data_valid_o", 1'b0, icache_data_valid_o);
                next_cycle();
            end
            is_last  = (k == int'(len) - 1);
            exp_word = beat_pattern(addr, k);
            rvalid_i = 1'b1;
            rid_i    = mst;
            rdata_i  = exp_word;
            rlast_i  = is_last;
            #1;
            check_bit("dcache_data_valid_o", mst == MST_DCACHE, dcache_data_valid_o);
            check_bit("icache_data_valid_o", mst == MST_ICACHE, icache_data_valid_o);
            check_bit("dcache_data_last_o", is_last && mst == MST_DCACHE, dcache_data_last_o);
            check_bit("icache_data_last_o", is_last && mst == MST_ICACHE, icache_data_last_o);
            check_data(mst == MST_ICACHE ? "icache_data_o" : "dcache_data_o", exp_word,
                       mst == MST_ICACHE ? icache_data_o : dcache_data_o);
            check_bit("arvalid_o", 1'b0, arvalid_o);
            check_bit("dcache_rd_ready_o", 1'b0, dcache_rd_ready_o);    // no grant mid burst
            check_bit("icache_rd_ready_o", 1'b0, icache_rd_ready_o);
            next_cycle();
        end
        rvalid_i = 1'b0;
        rlast_i  = 1'b0;
    endtask

    task automatic single_read(input master_e mst, input addr_t addr, input burst_len_t len,
                               input int ar_stall, input int gap_max);
        next_cycle();
        set_req(mst, addr, len);
        read_burst(mst, addr, len, ar_stall, gap_max);
    endtask

    task automatic test_single_dcache();
        single_read(MST_DCACHE, 32'h0000_1000, 8'd1, 0, 0);
        single_read(MST_DCACHE, 32'h0000_2040, 8'd4, 0, 0);
    endtask

    task automatic test_single_icache();
        single_read(MST_ICACHE, 32'h0040_0000, 8'd1, 0, 0);
        single_read(MST_ICACHE, 32'h0040_0100, 8'd4, 0, 0);
    endtask

    task automatic test_round_robin();
        master_e win;
        addr_t   d_addr;
        addr_t   i_addr;
        d_addr = 32'h0001_0000;
        i_addr = 32'h0002_0000;
        next_cycle();
        set_req(MST_DCACHE, d_addr, 8'd2);
        set_req(MST_ICACHE, i_addr, 8'd3);
        for (int n = 0; n < 6; n++) begin
            win = (last_winner == MST_DCACHE) ? MST_ICACHE : MST_DCACHE;
            read_burst(win, win == MST_DCACHE ? d_addr : i_addr,
                       win == MST_DCACHE ? 8'd2 : 8'd3, 0, 1);
            // winner asks again at once, so the next grant is another tie
            if (n < 4) begin
                if (win == MST_DCACHE) begin
                    d_addr = d_addr + addr_t'(256);
                    set_req(MST_DCACHE, d_addr, 8'd2);
                end else begin
                    i_addr = i_addr + addr_t'(256);
                    set_req(MST_ICACHE, i_addr, 8'd3);
                end
            end
        end
    endtask

    task automatic test_ar_backpressure();
        logic [31:0] r;
        rand_bits(3, r);
        single_read(MST_DCACHE, 32'h0000_3000, 8'd4, 1 + int'(r[2:0]) % 7, 0);
        rand_bits(3, r);
        single_read(MST_ICACHE, 32'h0000_4000, 8'd4, 1 + int'(r[2:0]) % 7, 0);
    endtask

    task automatic test_random_bursts();
        logic [31:0] r;
        master_e     m;
        addr_t       a;
        burst_len_t  l;
        for (int n = 0; n < 20; n++) begin
            rand_bits(1, r);
            m = r[0] ? MST_ICACHE : MST_DCACHE;
            rand_bits(30, r);
            a = {r[29:0], 2'b00};    // word aligned
            rand_bits(4, r);
            l = burst_len_t'(int'(r[3:0]) + 1);
            rand_bits(2, r);
            single_read(m, a, l, int'(r[1:0]), 3);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        rst_n_i           = 1'b0;
        dcache_rd_valid_i = 1'b0;
        dcache_rd_addr_i  = '0;
        dcache_rd_len_i   = '0;
        icache_rd_valid_i = 1'b0;
        icache_rd_addr_i  = '0;
        icache_rd_len_i   = '0;
        arready_i         = 1'b0;
        rid_i             = MST_DCACHE;
        rdata_i           = '0;
        rlast_i           = 1'b0;
        rvalid_i          = 1'b0;
        lfsr_q            = 32'hc5f9_682a;
        last_winner       = MST_ICACHE;    // data side wins the first tie
        repeat (8) @(posedge aclk);
        #5;
        check_bit("arvalid_o", 1'b0, arvalid_o);
        check_bit("dcache_rd_ready_o", 1'b0, dcache_rd_ready_o);
        check_bit("icache_rd_ready_o", 1'b0, icache_rd_ready_o);
        check_bit("dcache_data_valid_o", 1'b0, dcache_data_valid_o);
        check_bit("icache_data_valid_o", 1'b0, icache_data_valid_o);
        rst_n_i = 1'b1;
        test_single_dcache();
        test_single_icache();
        test_round_robin();
        test_ar_backpressure();
        test_random_bursts();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* tb.f */
verilog/axi_rd_pkg.sv
verilog/rd_req_if.sv
verilog/rd_arbiter_ctrl.sv
verilog/ar_channel_mux.sv
verilog/r_channel_router.sv
verilog/axi_rd_bridge_top.sv
testbench/tb_axi_rd_bridge.sv

/* run.sh */
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_axi_rd_bridge -f tb.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_axi_rd_bridge 2>&1)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
